// ==== hw/id_pkg.sv ====
// decode subset only covers lui, addi, add, sub, ld, sd, jal, jalr and the six branches
`default_nettype none

package id_pkg;

  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [INST_W-1:0]     inst_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_ADD = 4'd0;
  localparam alu_op_t ALU_SUB = 4'd1;
  localparam alu_op_t ALU_LUI = 4'd2; // pass imm through

  // conditional branches keep their funct3, jumps take the two free codes
  typedef logic [2:0] br_func_t;
  localparam br_func_t BR_JAL  = 3'd2;
  localparam br_func_t BR_JALR = 3'd3;

  typedef logic src2_sel_t;
  localparam src2_sel_t SRC2_REG = 1'b0;
  localparam src2_sel_t SRC2_IMM = 1'b1;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_OPIMM  = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;

endpackage

`default_nettype wire

// ==== hw/decode_if.sv ====
// fields of the held instruction; imm is already sign-extended to XLEN
`timescale 1ns/1ps
`default_nettype none

interface decode_if #(
  parameter int XLEN = 64
);
  import id_pkg::*;

  reg_addr_t       rs1;
  reg_addr_t       rs2;
  reg_addr_t       rd;
  logic [XLEN-1:0] imm;
  logic            br_en;
  br_func_t        br_func;
  alu_op_t         alu_op;
  src2_sel_t       src2_sel;
  logic            gpr_wen;
  logic            mem_ren;
  logic            mem_wen;
  logic            load_sel;
  logic            invalid;

  modport decoder (output rs1, rs2, rd, imm, br_en, br_func, alu_op, src2_sel,
                   gpr_wen, mem_ren, mem_wen, load_sel, invalid);
  modport fwd     (input rs1, rs2);
  modport branch  (input imm, br_en, br_func);

endinterface

`default_nettype wire

// ==== hw/bypass_if.sv ====
// later-stage results; an rd of zero means the stage has nothing to forward
`timescale 1ns/1ps
`default_nettype none

interface bypass_if #(
  parameter int XLEN = 64
);
  import id_pkg::*;

  reg_addr_t       es_rd;
  logic [XLEN-1:0] es_result;
  reg_addr_t       ms_rd;
  logic [XLEN-1:0] ms_result;
  reg_addr_t       ws_rd;
  logic [XLEN-1:0] ws_result;
  logic            es_load;   // es result not ready yet

  modport fwd (input es_rd, es_result, ms_rd, ms_result, ws_rd, ws_result, es_load);

endinterface

`default_nettype wire

// ==== hw/id_decoder.sv ====
// subset decode only; any other opcode or funct raises invalid with all enables low
`timescale 1ns/1ps
`default_nettype none

module id_decoder #(
  parameter int XLEN = 64
) (
  input wire id_pkg::inst_t i_inst,
  decode_if.decoder         dec
);
  import id_pkg::*;

  localparam logic [2:0] F3_ADD = 3'b000; // add, sub, addi, jalr
  localparam logic [2:0] F3_DW  = 3'b011; // ld, sd
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic            bad;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign dec.rs1 = i_inst[19:15];
  assign dec.rs2 = i_inst[24:20];
  assign dec.rd  = i_inst[11:7];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-31){i_inst[31]}}, i_inst[30:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    bad          = 1'b0;
    dec.imm      = imm_i;
    dec.br_en    = 1'b0;
    dec.br_func  = funct3;
    dec.alu_op   = ALU_ADD;
    dec.src2_sel = SRC2_IMM;
    dec.gpr_wen  = 1'b0;
    dec.mem_ren  = 1'b0;
    dec.mem_wen  = 1'b0;
    dec.load_sel = 1'b0;
    case (opcode)
      OP_LUI: begin
        dec.imm     = imm_u;
        dec.alu_op  = ALU_LUI;
        dec.gpr_wen = 1'b1;
      end
      OP_OPIMM: begin
        bad         = (funct3 != F3_ADD); // addi only
        dec.gpr_wen = 1'b1;
      end
      OP_OP: begin
        bad          = (funct3 != F3_ADD) || ((funct7 != F7_ADD) && (funct7 != F7_SUB));
        dec.alu_op   = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
        dec.src2_sel = SRC2_REG;
        dec.gpr_wen  = 1'b1;
      end
      OP_LOAD: begin
        bad          = (funct3 != F3_DW);
        dec.gpr_wen  = 1'b1;
        dec.mem_ren  = 1'b1;
        dec.load_sel = 1'b1;
      end
      OP_STORE: begin
        bad         = (funct3 != F3_DW);
        dec.imm     = imm_s;
        dec.mem_wen = 1'b1;
      end
      OP_BRANCH: begin
        // funct3 2 and 3 are not branches
        bad          = (funct3 == BR_JAL) || (funct3 == BR_JALR);
        dec.imm      = imm_b;
        dec.br_en    = 1'b1;
        dec.src2_sel = SRC2_REG;
      end
      OP_JAL: begin
        dec.imm     = imm_j;
        dec.br_en   = 1'b1;
        dec.br_func = BR_JAL;
        dec.gpr_wen = 1'b1;
      end
      OP_JALR: begin
        bad         = (funct3 != F3_ADD);
        dec.br_en   = 1'b1;
        dec.br_func = BR_JALR;
        dec.gpr_wen = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      dec.br_en    = 1'b0;
      dec.gpr_wen  = 1'b0;
      dec.mem_ren  = 1'b0;
      dec.mem_wen  = 1'b0;
      dec.load_sel = 1'b0;
    end
    dec.invalid = bad;
  end

endmodule

`default_nettype wire

// ==== hw/id_regfile.sv ====
// x0 reads zero; a write is only visible on the read ports from the next cycle
`timescale 1ns/1ps
`default_nettype none

module id_regfile #(
  parameter int XLEN = 64
) (
  input  wire                   i_clk,
  input  wire                   i_rst,
  input  wire id_pkg::reg_addr_t i_raddr1,
  output logic [XLEN-1:0]        o_rdata1,
  input  wire id_pkg::reg_addr_t i_raddr2,
  output logic [XLEN-1:0]        o_rdata2,
  input  wire                   i_wen,
  input  wire id_pkg::reg_addr_t i_waddr,
  input  wire [XLEN-1:0]        i_wdata
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = regs[i_raddr1]; // async read
  assign o_rdata2 = regs[i_raddr2];

endmodule

`default_nettype wire

// ==== hw/id_operand_fwd.sv ====
// stall is raised on any rs1/rs2 match, even when the instruction ignores rs2
`timescale 1ns/1ps
`default_nettype none

module id_operand_fwd #(
  parameter int XLEN = 64
) (
  decode_if.fwd           dec,
  bypass_if.fwd           byp,
  input  wire [XLEN-1:0] i_rf_rdata1,
  input  wire [XLEN-1:0] i_rf_rdata2,
  output logic [XLEN-1:0] o_rs1data,
  output logic [XLEN-1:0] o_rs2data,
  output logic            o_load_stall
);
  import id_pkg::*;

  // x0 never forwards
  function automatic logic hit(reg_addr_t dst, reg_addr_t src);
    return (dst != '0) && (dst == src);
  endfunction

  logic es_hit1;
  logic ms_hit1;
  logic ws_hit1;
  logic es_hit2;
  logic ms_hit2;
  logic ws_hit2;

  assign es_hit1 = hit(byp.es_rd, dec.rs1);
  assign ms_hit1 = hit(byp.ms_rd, dec.rs1);
  assign ws_hit1 = hit(byp.ws_rd, dec.rs1);
  assign es_hit2 = hit(byp.es_rd, dec.rs2);
  assign ms_hit2 = hit(byp.ms_rd, dec.rs2);
  assign ws_hit2 = hit(byp.ws_rd, dec.rs2);

  // youngest producer wins
  assign o_rs1data = es_hit1 ? byp.es_result :
                     ms_hit1 ? byp.ms_result :
                     ws_hit1 ? byp.ws_result : i_rf_rdata1;
  assign o_rs2data = es_hit2 ? byp.es_result :
                     ms_hit2 ? byp.ms_result :
                     ws_hit2 ? byp.ws_result : i_rf_rdata2;

  assign o_load_stall = byp.es_load && (es_hit1 || es_hit2); // wait for mem stage

endmodule

`default_nettype wire

// ==== hw/id_branch_unit.sv ====
// operands must be the forwarded values; target is meaningless when not taken
`timescale 1ns/1ps
`default_nettype none

module id_branch_unit #(
  parameter int XLEN = 64
) (
  input  wire             i_valid,
  decode_if.branch        dec,
  input  wire [XLEN-1:0] i_pc,
  input  wire [XLEN-1:0] i_rs1data,
  input  wire [XLEN-1:0] i_rs2data,
  output logic            o_br_taken,
  output logic [XLEN-1:0] o_br_target
);
  import id_pkg::*;

  logic            eq;
  logic            lt;
  logic            ltu;
  logic            cond;
  logic            is_jalr;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] sum;

  assign eq  = (i_rs1data == i_rs2data);
  assign lt  = ($signed(i_rs1data) < $signed(i_rs2data));
  assign ltu = (i_rs1data < i_rs2data);

  always_comb begin
    case (dec.br_func)
      3'b000:           cond = eq;   // beq
      3'b001:           cond = !eq;  // bne
      3'b100:           cond = lt;   // blt
      3'b101:           cond = !lt;  // bge
      3'b110:           cond = ltu;  // bltu
      3'b111:           cond = !ltu; // bgeu
      BR_JAL, BR_JALR:  cond = 1'b1;
      default:          cond = 1'b0;
    endcase
  end

  assign is_jalr     = (dec.br_func == BR_JALR);
  assign base        = is_jalr ? i_rs1data : i_pc;
  assign sum         = base + dec.imm;
  assign o_br_target = is_jalr ? {sum[XLEN-1:1], 1'b0} : sum;

  assign o_br_taken = i_valid && dec.br_en && cond;

endmodule

`default_nettype wire

// ==== hw/id_stage.sv ====
// one-entry decode stage; bypass results must be valid whenever their rd is non-zero
`timescale 1ns/1ps
`default_nettype none

module id_stage #(
  parameter int XLEN = 64
) (
  input  wire                     i_clk,
  input  wire                     i_rst,
  // flow control
  input  wire                     i_fs_to_ds_valid,
  input  wire [XLEN-1:0]          i_fs_pc,
  input  wire id_pkg::inst_t      i_fs_inst,
  input  wire                     i_es_allowin,
  output logic                    o_ds_allowin,
  output logic                    o_ds_to_es_valid,
  // write back
  input  wire                     i_ws_wen,
  input  wire id_pkg::reg_addr_t  i_ws_waddr,
  input  wire [XLEN-1:0]          i_ws_wdata,
  // bypass
  input  wire id_pkg::reg_addr_t  i_es_rd,
  input  wire [XLEN-1:0]          i_es_result,
  input  wire                     i_es_load_sel,
  input  wire id_pkg::reg_addr_t  i_ms_rd,
  input  wire [XLEN-1:0]          i_ms_result,
  input  wire id_pkg::reg_addr_t  i_ws_rd,
  input  wire [XLEN-1:0]          i_ws_result,
  // to es
  output logic [XLEN-1:0]         o_rs1data,
  output logic [XLEN-1:0]         o_rs2data,
  output logic [XLEN-1:0]         o_imm,
  output logic [XLEN-1:0]         o_pc,
  output id_pkg::reg_addr_t       o_rd,
  output id_pkg::alu_op_t         o_alu_op,
  output id_pkg::src2_sel_t       o_src2_sel,
  output logic                    o_gpr_wen,
  output logic                    o_mem_ren,
  output logic                    o_mem_wen,
  output logic                    o_load_sel,
  output logic                    o_invalid,
  // to fs
  output logic                    o_br_taken,
  output logic                    o_br_stall,
  output logic [XLEN-1:0]         o_br_target
);
  import id_pkg::*;

  logic            ds_valid;
  logic            ds_ready_go;
  logic            load_stall;
  logic [XLEN-1:0] ds_pc;
  inst_t           ds_inst;
  logic [XLEN-1:0] rf_rdata1;
  logic [XLEN-1:0] rf_rdata2;

  decode_if #(.XLEN(XLEN)) dec ();
  bypass_if #(.XLEN(XLEN)) byp ();

  assign ds_ready_go      = !load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_pc   <= i_fs_pc;
      ds_inst <= i_fs_inst;
    end
  end

  assign byp.es_rd     = i_es_rd;
  assign byp.es_result = i_es_result;
  assign byp.es_load   = i_es_load_sel;
  assign byp.ms_rd     = i_ms_rd;
  assign byp.ms_result = i_ms_result;
  assign byp.ws_rd     = i_ws_rd;
  assign byp.ws_result = i_ws_result;

  assign o_pc       = ds_pc;
  assign o_imm      = dec.imm;
  assign o_rd       = dec.rd;
  assign o_alu_op   = dec.alu_op;
  assign o_src2_sel = dec.src2_sel;
  assign o_gpr_wen  = dec.gpr_wen;
  assign o_mem_ren  = dec.mem_ren;
  assign o_mem_wen  = dec.mem_wen;
  assign o_load_sel = dec.load_sel;
  assign o_invalid  = dec.invalid;

  // target waits on a load still in es
  assign o_br_stall = o_br_taken && load_stall;

  id_decoder #(.XLEN(XLEN)) u_decoder (
    .i_inst (ds_inst),
    .dec    (dec)
  );

  id_regfile #(.XLEN(XLEN)) u_regfile (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_raddr1 (dec.rs1),
    .o_rdata1 (rf_rdata1),
    .i_raddr2 (dec.rs2),
    .o_rdata2 (rf_rdata2),
    .i_wen    (i_ws_wen),
    .i_waddr  (i_ws_waddr),
    .i_wdata  (i_ws_wdata)
  );

  id_operand_fwd #(.XLEN(XLEN)) u_fwd (
    .dec          (dec),
    .byp          (byp),
    .i_rf_rdata1  (rf_rdata1),
    .i_rf_rdata2  (rf_rdata2),
    .o_rs1data    (o_rs1data),
    .o_rs2data    (o_rs2data),
    .o_load_stall (load_stall)
  );

  id_branch_unit #(.XLEN(XLEN)) u_branch (
    .i_valid     (ds_valid),
    .dec         (dec),
    .i_pc        (ds_pc),
    .i_rs1data   (o_rs1data),
    .i_rs2data   (o_rs2data),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

`default_nettype wire

// ==== dv/id_stage_assert.sv ====
// bound to id_stage; keeps its own copy of the stage register and register file
`timescale 1ns/1ps
`default_nettype none

module id_stage_assert #(
  parameter int XLEN = 64
) (
  input wire i_clk, i_rst, i_fs_to_ds_valid, i_es_allowin, i_ws_wen, i_es_load_sel,
  input wire [31:0] i_fs_inst,
  input wire [4:0] i_ws_waddr, i_es_rd, i_ms_rd, i_ws_rd, o_rd,
  input wire [XLEN-1:0] i_fs_pc, i_ws_wdata, i_es_result, i_ms_result, i_ws_result,
  input wire [XLEN-1:0] o_rs1data, o_rs2data, o_imm, o_pc, o_br_target,
  input wire [3:0] o_alu_op,
  input wire o_ds_allowin, o_ds_to_es_valid, o_src2_sel, o_gpr_wen, o_mem_ren, o_mem_wen,
  input wire o_load_sel, o_invalid, o_br_taken, o_br_stall
);
  import id_pkg::*;

  int unsigned     fail_count = 0;
  logic [XLEN-1:0] shadow [32];
  logic [31:0]     inst_q;
  logic [XLEN-1:0] pc_q;
  logic            valid_q;
  logic            have_inst;
  logic [XLEN-1:0] x1;
  logic [XLEN-1:0] x2;
  logic [XLEN-1:0] exp_imm;
  logic [XLEN-1:0] exp_target;
  logic [4:0]      exp_en; // gpr_wen, mem_ren, mem_wen, load_sel, invalid
  alu_op_t         exp_alu;
  src2_sel_t       exp_src2;
  logic            alu_chk; // only alu ops and memory ops have a defined alu field
  logic            stall;
  logic            cond;
  logic            exp_taken;
  logic            allowin;
  logic [2:0]      f3;

  // first non-zero match, youngest stage first
  function automatic logic [XLEN-1:0] operand(input logic [4:0] src);
    if (src == 5'd0) return '0;
    if (src == i_es_rd) return i_es_result;
    if (src == i_ms_rd) return i_ms_result;
    if (src == i_ws_rd) return i_ws_result;
    return shadow[src];
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q   <= 1'b0;
      have_inst <= 1'b0;
      for (int i = 0; i < 32; i++) shadow[i] <= '0;
    end else begin
      if (i_ws_wen && (i_ws_waddr != 5'd0)) shadow[i_ws_waddr] <= i_ws_wdata;
      if (allowin) valid_q <= i_fs_to_ds_valid;
      if (allowin && i_fs_to_ds_valid) begin
        inst_q    <= i_fs_inst;
        pc_q      <= i_fs_pc;
        have_inst <= 1'b1;
      end
    end
  end

  always_comb begin
    f3       = inst_q[14:12];
    x1       = operand(inst_q[19:15]);
    x2       = operand(inst_q[24:20]);
    stall    = i_es_load_sel && (i_es_rd != 5'd0) &&
               ((i_es_rd == inst_q[19:15]) || (i_es_rd == inst_q[24:20]));
    allowin  = !valid_q || (!stall && i_es_allowin);
    exp_imm  = XLEN'($signed(inst_q[31:20]));
    exp_en   = 5'b00001;
    exp_alu  = ALU_ADD;
    exp_src2 = SRC2_IMM;
    alu_chk  = 1'b0;
    cond     = 1'b0;
    case (inst_q[6:0])
      7'h37: begin
        exp_imm = XLEN'($signed({inst_q[31:12], 12'b0}));
        exp_en  = 5'b10000;
        exp_alu = ALU_LUI;
        alu_chk = 1'b1;
      end
      7'h13: begin
        exp_en  = (f3 == 3'd0) ? 5'b10000 : 5'b00001;
        alu_chk = 1'b1;
      end
      7'h33: begin
        exp_en   = ((f3 == 3'd0) && ((inst_q[31:25] == 7'h00) || (inst_q[31:25] == 7'h20)))
                   ? 5'b10000 : 5'b00001;
        exp_alu  = (inst_q[31:25] == 7'h20) ? ALU_SUB : ALU_ADD;
        exp_src2 = SRC2_REG;
        alu_chk  = 1'b1;
      end
      7'h03: begin
        exp_en  = (f3 == 3'd3) ? 5'b11010 : 5'b00001;
        alu_chk = 1'b1; // address add
      end
      7'h23: begin
        exp_imm = XLEN'($signed({inst_q[31:25], inst_q[11:7]}));
        exp_en  = (f3 == 3'd3) ? 5'b00100 : 5'b00001;
        alu_chk = 1'b1;
      end
      7'h63: begin
        exp_imm = XLEN'($signed({inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0}));
        exp_en  = ((f3 == 3'd2) || (f3 == 3'd3)) ? 5'b00001 : 5'b00000;
        case (f3)
          3'd0: cond = (x1 == x2);
          3'd1: cond = (x1 != x2);
          3'd4: cond = ($signed(x1) < $signed(x2));
          3'd5: cond = ($signed(x1) >= $signed(x2));
          3'd6: cond = (x1 < x2);
          default: cond = (x1 >= x2);
        endcase
      end
      7'h6f: begin
        exp_imm = XLEN'($signed({inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0}));
        exp_en  = 5'b10000;
        cond    = 1'b1;
      end
      7'h67: begin
        exp_en = (f3 == 3'd0) ? 5'b10000 : 5'b00001;
        cond   = 1'b1;
      end
      default: exp_en = 5'b00001;
    endcase
    exp_taken  = valid_q && !exp_en[0] && cond;
    exp_target = (inst_q[6:0] == 7'h67) ? ((x1 + exp_imm) & ~XLEN'(1)) : (pc_q + exp_imm);
  end

  a_reset: assert property (@(posedge i_clk) i_rst |=> !o_ds_to_es_valid && !o_br_taken
                            && !o_br_stall && o_ds_allowin)
    else begin
      fail_count++;
      $error("outputs not idle after reset");
    end
  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_to_es_valid && !i_es_allowin |=> $stable({o_imm, o_pc, o_rd, o_alu_op, o_src2_sel,
    o_gpr_wen, o_mem_ren, o_mem_wen, o_load_sel, o_invalid}))
    else begin
      fail_count++;
      $error("execute-bound output changed under back-pressure");
    end
  a_rs1: assert property (@(posedge i_clk) disable iff (i_rst) have_inst |-> o_rs1data == x1)
    else begin
      fail_count++;
      $error("CHECK FAILED o_rs1data exp %h got %h", $sampled(x1), $sampled(o_rs1data));
    end
  a_rs2: assert property (@(posedge i_clk) disable iff (i_rst) have_inst |-> o_rs2data == x2)
    else begin
      fail_count++;
      $error("CHECK FAILED o_rs2data exp %h got %h", $sampled(x2), $sampled(o_rs2data));
    end
  a_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_to_es_valid == (valid_q && !stall))
    else begin
      fail_count++;
      $error("CHECK FAILED o_ds_to_es_valid exp %h got %h", $sampled(valid_q && !stall),
             $sampled(o_ds_to_es_valid));
    end
  a_allowin: assert property (@(posedge i_clk) disable iff (i_rst) o_ds_allowin == allowin)
    else begin
      fail_count++;
      $error("CHECK FAILED o_ds_allowin exp %h got %h", $sampled(allowin),
             $sampled(o_ds_allowin));
    end
  a_pc: assert property (@(posedge i_clk) disable iff (i_rst) have_inst |-> o_pc == pc_q)
    else begin
      fail_count++;
      $error("CHECK FAILED o_pc exp %h got %h", $sampled(pc_q), $sampled(o_pc));
    end
  a_dec: assert property (@(posedge i_clk) disable iff (i_rst)
    have_inst |-> {o_gpr_wen, o_mem_ren, o_mem_wen, o_load_sel, o_invalid} == exp_en)
    else begin
      fail_count++;
      $error("CHECK FAILED enables exp %h got %h", $sampled(exp_en),
             $sampled({o_gpr_wen, o_mem_ren, o_mem_wen, o_load_sel, o_invalid}));
    end
  a_rd: assert property (@(posedge i_clk) disable iff (i_rst)
    have_inst && exp_en[4] |-> o_rd == inst_q[11:7])
    else begin
      fail_count++;
      $error("CHECK FAILED o_rd exp %h got %h", $sampled(inst_q[11:7]), $sampled(o_rd));
    end
  a_alu: assert property (@(posedge i_clk) disable iff (i_rst)
    have_inst && alu_chk && !exp_en[0] |-> o_alu_op == exp_alu)
    else begin
      fail_count++;
      $error("CHECK FAILED o_alu_op exp %h got %h", $sampled(exp_alu), $sampled(o_alu_op));
    end
  a_src2: assert property (@(posedge i_clk) disable iff (i_rst)
    have_inst && alu_chk && !exp_en[0] |-> o_src2_sel == exp_src2)
    else begin
      fail_count++;
      $error("CHECK FAILED o_src2_sel exp %h got %h", $sampled(exp_src2),
             $sampled(o_src2_sel));
    end
  a_imm: assert property (@(posedge i_clk) disable iff (i_rst)
    have_inst && !exp_en[0] |-> o_imm == exp_imm)
    else begin
      fail_count++;
      $error("CHECK FAILED o_imm exp %h got %h", $sampled(exp_imm), $sampled(o_imm));
    end
  a_taken: assert property (@(posedge i_clk) disable iff (i_rst)
    have_inst |-> o_br_taken == exp_taken)
    else begin
      fail_count++;
      $error("CHECK FAILED o_br_taken exp %h got %h", $sampled(exp_taken), $sampled(o_br_taken));
    end
  a_br_stall: assert property (@(posedge i_clk) disable iff (i_rst)
    have_inst |-> o_br_stall == (exp_taken && stall))
    else begin
      fail_count++;
      $error("CHECK FAILED o_br_stall exp %h got %h", $sampled(exp_taken && stall),
             $sampled(o_br_stall));
    end
  a_target: assert property (@(posedge i_clk) disable iff (i_rst)
    exp_taken |-> o_br_target == exp_target)
    else begin
      fail_count++;
      $error("CHECK FAILED o_br_target exp %h got %h", $sampled(exp_target),
             $sampled(o_br_target));
    end

endmodule

bind id_stage id_stage_assert #(.XLEN(XLEN)) u_chk (.*);

`default_nettype wire

// ==== dv/tb_id_stage.sv ====
// XLEN 64 only; checking lives in the bound id_stage_assert instance
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

  localparam int XLEN  = 64;
  localparam int LIMIT = 16 + 64 + 400 * 2;

  logic i_clk, i_rst, i_fs_to_ds_valid, i_es_allowin, i_ws_wen, i_es_load_sel;
  logic [31:0] i_fs_inst;
  logic [4:0] i_ws_waddr, i_es_rd, i_ms_rd, i_ws_rd, o_rd;
  logic [XLEN-1:0] i_fs_pc, i_ws_wdata, i_es_result, i_ms_result, i_ws_result;
  logic [XLEN-1:0] o_rs1data, o_rs2data, o_imm, o_pc, o_br_target;
  logic [3:0] o_alu_op;
  logic o_ds_allowin, o_ds_to_es_valid, o_src2_sel, o_gpr_wen, o_mem_ren, o_mem_wen;
  logic o_load_sel, o_invalid, o_br_taken, o_br_stall;
  int unsigned cycles;
  int unsigned sent;

  id_stage #(.XLEN(XLEN)) DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display("summary: %0d instructions sent, %0d checks failed", sent, DUT.u_chk.fail_count);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // small register range so bypass indices hit often
  function automatic logic [31:0] pick_inst();
    logic [4:0]  a;
    logic [4:0]  b;
    logic [4:0]  d;
    logic [11:0] imm;
    logic [2:0]  f3;
    a   = 5'($urandom % 8);
    b   = 5'($urandom % 8);
    d   = 5'($urandom % 8);
    imm = 12'($urandom);
    f3  = 3'($urandom % 6);
    if (f3 >= 3'd2) f3 = f3 + 3'd2; // skip codes 2 and 3
    case ($urandom % 10)
      0: return {20'($urandom), d, 7'h37};
      1: return {imm, a, 3'd0, d, 7'h13};
      2: return {(($urandom % 2) == 1) ? 7'h20 : 7'h00, b, a, 3'd0, d, 7'h33};
      3: return {imm, a, 3'd3, d, 7'h03};
      4: return {imm[11:5], b, a, 3'd3, imm[4:0], 7'h23};
      5: return enc_j(21'($urandom), d);
      6: return {imm, a, 3'd0, d, 7'h67};
      7, 8: return enc_b(13'($urandom), b, a, f3);
      default: return $urandom;
    endcase
  endfunction

  task automatic drive_side(input bit mix);
    i_es_allowin  <= mix ? (($urandom % 4) != 0) : 1'b1;
    i_es_load_sel <= mix && (($urandom % 3) == 0);
    i_es_rd       <= mix ? 5'($urandom % 8) : 5'd0;
    i_ms_rd       <= mix ? 5'($urandom % 8) : 5'd0;
    i_ws_rd       <= mix ? 5'($urandom % 8) : 5'd0;
    i_es_result   <= {$urandom, $urandom};
    i_ms_result   <= {$urandom, $urandom};
    i_ws_result   <= {$urandom, $urandom};
    i_ws_wen      <= mix && (($urandom % 2) == 1);
    i_ws_waddr    <= 5'($urandom % 8);
    i_ws_wdata    <= {$urandom, $urandom};
  endtask

  // hold the instruction until the stage takes it
  task automatic issue(input logic [31:0] inst, input bit mix);
    bit taken;
    i_fs_to_ds_valid <= 1'b1;
    i_fs_inst        <= inst;
    i_fs_pc          <= {$urandom, $urandom};
    do begin
      @(negedge i_clk);
      taken = o_ds_allowin;
      @(posedge i_clk);
      drive_side(mix);
    end while (!taken);
    sent++;
  endtask

  initial begin
    void'($urandom(32'hb70c));
    sent             = 0;
    i_rst            = 1'b1;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = '0;
    i_fs_pc          = '0;
    i_es_allowin     = 1'b1;
    i_ws_wen         = 1'b0;
    i_ws_waddr       = '0;
    i_ws_wdata       = '0;
    i_es_rd          = '0;
    i_es_result      = '0;
    i_es_load_sel    = 1'b0;
    i_ms_rd          = '0;
    i_ms_result      = '0;
    i_ws_rd          = '0;
    i_ws_result      = '0;
    repeat (16) @(posedge i_clk);
    i_rst <= 1'b0;
    for (int i = 0; i < 64; i++) begin
      i_ws_wen   <= 1'b1;
      i_ws_waddr <= 5'(i % 32);
      i_ws_wdata <= {$urandom, $urandom};
      @(posedge i_clk);
    end
    i_ws_wen <= 1'b0;
    // one of each opcode, then bad funct codes and an unknown opcode
    issue({20'h80001, 5'd1, 7'h37}, 1'b0);
    issue({12'hf85, 5'd2, 3'd0, 5'd3, 7'h13}, 1'b0);
    issue({7'h00, 5'd4, 5'd5, 3'd0, 5'd6, 7'h33}, 1'b0);
    issue({7'h20, 5'd7, 5'd8, 3'd0, 5'd9, 7'h33}, 1'b0);
    issue({12'h810, 5'd10, 3'd3, 5'd11, 7'h03}, 1'b0);
    issue({7'h7c, 5'd12, 5'd13, 3'd3, 5'd14, 7'h23}, 1'b0);
    issue(enc_j(21'h1ffff4, 5'd1), 1'b0);
    issue({12'h013, 5'd15, 3'd0, 5'd1, 7'h67}, 1'b0);
    for (int f = 0; f < 8; f++) issue(enc_b(13'h1ff0, 5'd16, 5'd17, 3'(f)), 1'b0);
    issue({12'h001, 5'd2, 3'd1, 5'd3, 7'h13}, 1'b0);
    issue(32'h0000_000b, 1'b0);
    while (sent < 400) issue(pick_inst(), 1'b1);
    i_fs_to_ds_valid <= 1'b0;
    drive_side(1'b0);
    repeat (4) @(posedge i_clk);
    $display("summary: %0d instructions sent, %0d checks failed", sent, DUT.u_chk.fail_count);
    if (DUT.u_chk.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/id_pkg.sv
hw/decode_if.sv
hw/bypass_if.sv
hw/id_decoder.sv
hw/id_regfile.sv
hw/id_operand_fwd.sv
hw/id_branch_unit.sv
hw/id_stage.sv
dv/id_stage_assert.sv
dv/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_id_stage -f sim.f -o sim_id_stage
out=$(./obj_dir/sim_id_stage +verilator+error+limit+100000)
echo "$out"
if echo "$out" | grep -q "TEST PASSED"; then
  exit 0
fi
exit 1
